//--- design/boot_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Address map is fixed at four banks of 512 words, 8 KB in total
// Byte address bits 1:0 are ignored by every port
// ~~~~~~~~~~~~~~~~~~~~
package boot_pkg;

   localparam int ADR_W      = 13;             // Byte address, 8 KB
   localparam int DAT_W      = 32;             // One word
   localparam int BANK_AW    = 9;              // Word address inside a bank
   localparam int NUM_BANKS  = 4;
   localparam int BANK_W     = 2;              // Bank index width
   localparam int SEL_W      = 4;              // Byte lanes per word
   localparam int LANE_W     = 8;              // Bits per byte lane
   localparam int WORD_BYTES = 4;              // PC step

   localparam int BANK_MSB   = 12;             // Bank select field
   localparam int BANK_LSB   = 11;
   localparam int WORD_MSB   = 10;             // Word select field
   localparam int WORD_LSB   = 2;

   typedef logic [ADR_W-1:0] adr_t;
   typedef logic [DAT_W-1:0] word_t;

   // Data port request, held by the master until ack
   typedef struct packed {
      adr_t             adr;
      word_t            dat;
      logic             we;
      logic [SEL_W-1:0] sel;                   // Byte lane enables
      logic             stb;
   } wb_req_t;

   typedef struct packed {
      logic valid;
      adr_t pc;
   } fetch_req_t;

   typedef struct packed {
      adr_t  pc;
      word_t instr;
   } fetch_rsp_t;

endpackage

//--- design/fetch_pc.sv
// ~~~~~~~~~~~~~~~~~~~~
// Issues one fetch per cycle while run_i is high
// Redirect wins over run and loads even when stopped
// ~~~~~~~~~~~~~~~~~~~~
module fetch_pc #(
   parameter boot_pkg::adr_t RESET_PC = '0     // Boot vector
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 run_i,         // Fetch enable
   input  logic                 redirect_i,    // Load new target
   input  boot_pkg::adr_t       redirect_pc_i,
   output boot_pkg::fetch_req_t req_o          // To bank read and align
);

   boot_pkg::adr_t pc_q;                       // Address presented this cycle
   boot_pkg::adr_t pc_next;                    // Sequential successor

   // One word ahead, wraps at the top of the 8 KB space
   assign pc_next = pc_q + boot_pkg::adr_t'(boot_pkg::WORD_BYTES);

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q <= RESET_PC;                     // Back to boot vector
      end else if (redirect_i) begin
         pc_q <= redirect_pc_i;                // Branch target issued next
      end else if (run_i) begin
         pc_q <= pc_next;                      // Step while running
      end
   end

   // Request goes out in the same cycle the counter holds it
   always_comb begin
      req_o.valid = run_i;                     // No fetch when stopped
      req_o.pc    = pc_q;
   end

endmodule

//--- design/ram_bank.sv
// ~~~~~~~~~~~~~~~~~~~~
// 512 x 32 inferred RAM with read-only port A and byte-write port B
// Same-word access on both ports in one cycle is undefined
// ~~~~~~~~~~~~~~~~~~~~
module ram_bank (
   input  logic                        clk,
   input  logic                        a_en_i,    // Port A read enable
   input  logic [boot_pkg::BANK_AW-1:0] a_adr_i,
   output boot_pkg::word_t             a_dat_o,
   input  logic                        b_en_i,    // Port B access enable
   input  logic [boot_pkg::SEL_W-1:0]  b_we_i,    // Per-lane write enables
   input  logic [boot_pkg::BANK_AW-1:0] b_adr_i,
   input  boot_pkg::word_t             b_dat_i,
   output boot_pkg::word_t             b_dat_o
);

   boot_pkg::word_t mem [2**boot_pkg::BANK_AW]; // Contents start undefined

   // Port A, synchronous read, output holds when idle
   always_ff @(posedge clk) begin
      if (a_en_i) begin
         a_dat_o <= mem[a_adr_i];
      end
   end

   // Port B, byte writes with write-first read data
   always_ff @(posedge clk) begin
      if (b_en_i) begin
         for (int i = 0; i < boot_pkg::SEL_W; i++) begin
            if (b_we_i[i]) begin
               mem[b_adr_i][i*boot_pkg::LANE_W +: boot_pkg::LANE_W] <=
                  b_dat_i[i*boot_pkg::LANE_W +: boot_pkg::LANE_W];
               b_dat_o[i*boot_pkg::LANE_W +: boot_pkg::LANE_W] <=
                  b_dat_i[i*boot_pkg::LANE_W +: boot_pkg::LANE_W]; // New byte
            end else begin
               b_dat_o[i*boot_pkg::LANE_W +: boot_pkg::LANE_W] <=
                  mem[b_adr_i][i*boot_pkg::LANE_W +: boot_pkg::LANE_W]; // Old byte
            end
         end
      end
   end

endmodule

//--- design/bootram.sv
// ~~~~~~~~~~~~~~~~~~~~
// Fetch word returns one cycle after the address, every cycle
// Data port acks every second cycle while stb is held, no back-pressure
// ~~~~~~~~~~~~~~~~~~~~
module bootram (
   input  logic              clk,
   input  logic              reset,
   input  boot_pkg::adr_t    if_adr_i,         // Fetch address
   output boot_pkg::word_t   if_data_o,        // Fetch word, one cycle later
   input  boot_pkg::wb_req_t dwb_req_i,        // Data port request
   output boot_pkg::word_t   dwb_dat_o,        // Valid while ack is high
   output logic              dwb_ack_o
);

   logic [boot_pkg::BANK_W-1:0]    if_bank;    // Bank of current fetch
   logic [boot_pkg::BANK_W-1:0]    if_bank_q;  // Bank that was read
   logic [boot_pkg::BANK_W-1:0]    dwb_bank;
   logic [boot_pkg::BANK_W-1:0]    dwb_bank_q;
   logic                           dwb_take;   // Access accepted this cycle
   logic [boot_pkg::SEL_W-1:0]     dwb_web;    // Byte write enables
   logic [boot_pkg::NUM_BANKS-1:0] a_en;
   logic [boot_pkg::NUM_BANKS-1:0] b_en;
   boot_pkg::word_t                a_dat [boot_pkg::NUM_BANKS];
   boot_pkg::word_t                b_dat [boot_pkg::NUM_BANKS];

   assign if_bank  = if_adr_i[boot_pkg::BANK_MSB:boot_pkg::BANK_LSB];
   assign dwb_bank = dwb_req_i.adr[boot_pkg::BANK_MSB:boot_pkg::BANK_LSB];

   // Only the edge that raises ack performs the access
   assign dwb_take = dwb_req_i.stb & ~dwb_ack_o;
   assign dwb_web  = {boot_pkg::SEL_W{dwb_req_i.we}} & dwb_req_i.sel;

   for (genvar b = 0; b < boot_pkg::NUM_BANKS; b++) begin : g_bank
      assign a_en[b] = (if_bank == boot_pkg::BANK_W'(b));             // Read only the hit bank
      assign b_en[b] = dwb_take & (dwb_bank == boot_pkg::BANK_W'(b));

      ram_bank ram_bank_inst (
         .clk     (clk),
         .a_en_i  (a_en[b]),
         .a_adr_i (if_adr_i[boot_pkg::WORD_MSB:boot_pkg::WORD_LSB]),
         .a_dat_o (a_dat[b]),
         .b_en_i  (b_en[b]),
         .b_we_i  (dwb_web),
         .b_adr_i (dwb_req_i.adr[boot_pkg::WORD_MSB:boot_pkg::WORD_LSB]),
         .b_dat_i (dwb_req_i.dat),
         .b_dat_o (b_dat[b])
      );
   end

   // Bank selects follow the RAM read by one cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         if_bank_q  <= '0;
         dwb_bank_q <= '0;
      end else begin
         if_bank_q <= if_bank;                 // Fetch reads every cycle
         if (dwb_take) begin
            dwb_bank_q <= dwb_bank;            // Held through the ack cycle
         end
      end
   end

   // One-cycle ack, low for a cycle between back-to-back strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         dwb_ack_o <= 1'b0;
      end else begin
         dwb_ack_o <= dwb_take;
      end
   end

   assign if_data_o = a_dat[if_bank_q];        // Mux matches bank read
   assign dwb_dat_o = b_dat[dwb_bank_q];

endmodule

//--- design/fetch_align.sv
// ~~~~~~~~~~~~~~~~~~~~
// Matches the one-cycle RAM latency, results cannot be stalled
// ~~~~~~~~~~~~~~~~~~~~
module fetch_align (
   input  logic                 clk,
   input  logic                 reset,
   input  boot_pkg::fetch_req_t req_i,         // Request seen by the RAM
   input  boot_pkg::word_t      instr_i,       // Word read for that request
   output logic                 valid_o,
   output boot_pkg::fetch_rsp_t rsp_o
);

   logic           valid_q;                    // Fetch in the bank read stage
   boot_pkg::adr_t pc_q;                       // Its address

   // Valid is control, cleared on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= req_i.valid;
      end
   end

   // Capture the pc at the same edge that clocks the RAM read
   always_ff @(posedge clk) begin
      if (req_i.valid) begin
         pc_q <= req_i.pc;                     // Holds while stopped
      end
   end

   assign valid_o = valid_q;

   always_comb begin
      rsp_o.pc    = pc_q;
      rsp_o.instr = instr_i;                   // Arrives with the pc
   end

endmodule

//--- design/boot_subsys_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Boot memory with three-stage fetch port and Wishbone-style data port
// Image is loaded through the data port, contents start undefined
// ~~~~~~~~~~~~~~~~~~~~
module boot_subsys_top #(
   parameter boot_pkg::adr_t RESET_PC = '0     // First fetch address
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 run_i,         // Fetch enable
   input  logic                 redirect_i,
   input  boot_pkg::adr_t       redirect_pc_i,
   input  boot_pkg::wb_req_t    dwb_req_i,     // Data port request
   output boot_pkg::word_t      dwb_dat_o,
   output logic                 dwb_ack_o,
   output logic                 fetch_valid_o, // One edge after issue
   output boot_pkg::fetch_rsp_t fetch_o
);

   boot_pkg::fetch_req_t if_req;               // Stage 1 to stages 2 and 3
   boot_pkg::word_t      if_data;              // Stage 2 to stage 3

   // Stage 1, address generation
   fetch_pc #(
      .RESET_PC (RESET_PC)
   ) fetch_pc_inst (
      .clk           (clk),
      .reset         (reset),
      .run_i         (run_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .req_o         (if_req)
   );

   // Stage 2, bank read and data port
   bootram bootram_inst (
      .clk       (clk),
      .reset     (reset),
      .if_adr_i  (if_req.pc),
      .if_data_o (if_data),
      .dwb_req_i (dwb_req_i),
      .dwb_dat_o (dwb_dat_o),
      .dwb_ack_o (dwb_ack_o)
   );

   // Stage 3, response alignment
   fetch_align fetch_align_inst (
      .clk     (clk),
      .reset   (reset),
      .req_i   (if_req),
      .instr_i (if_data),
      .valid_o (fetch_valid_o),
      .rsp_o   (fetch_o)
   );

endmodule

//--- dv/boot_subsys_sva.sv
// ~~~~~~~~~~~~~~~~~~~~
// Data port handshake and fetch timing checks, bound into the top level
// ~~~~~~~~~~~~~~~~~~~~
module boot_subsys_sva (
   input logic              clk,
   input logic              reset,
   input logic              run_i,           // Fetch issued this cycle
   input boot_pkg::wb_req_t dwb_req_i,
   input logic              dwb_ack_i,
   input logic              fetch_valid_i
);
   timeunit 1ns;
   timeprecision 1ps;

   ack_single_a: assert property (@(posedge clk) disable iff (reset)
      dwb_ack_i |=> !dwb_ack_i)
      else $error("dwb_ack_o high two cycles running");

   // Ack only for a strobe seen while ack was low
   ack_after_stb_a: assert property (@(posedge clk) disable iff (reset)
      dwb_ack_i |-> $past(dwb_req_i.stb && !dwb_ack_i))
      else $error("dwb_ack_o without a preceding strobe");

   fetch_issue_a: assert property (@(posedge clk) disable iff (reset)
      run_i |=> fetch_valid_i)
      else $error("Fetch result missing one cycle after issue");

   fetch_idle_a: assert property (@(posedge clk) disable iff (reset)
      !run_i |=> !fetch_valid_i)
      else $error("Fetch result without an issue");

   reset_quiet_a: assert property (@(posedge clk)
      reset |=> (!dwb_ack_i && !fetch_valid_i))
      else $error("Ack or fetch valid high during reset");

endmodule

bind boot_subsys_top boot_subsys_sva boot_subsys_sva_inst (
   .clk           (clk),
   .reset         (reset),
   .run_i         (run_i),
   .dwb_req_i     (dwb_req_i),
   .dwb_ack_i     (dwb_ack_o),
   .fetch_valid_i (fetch_valid_o)
);

//--- dv/boot_subsys_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Directed tests, no fetch result comes from a word written in the same cycle
// Stops at the first mismatch, a watchdog bounds the run
// ~~~~~~~~~~~~~~~~~~~~
module boot_subsys_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int             CLK_PERIOD   = 8;
   localparam int             RESET_CYCLES = 16;
   localparam int             WAIT_LIMIT   = 16;        // Edges allowed for any handshake
   localparam boot_pkg::adr_t BOOT_PC      = 13'h07F0;  // Four words below bank 1
   localparam boot_pkg::adr_t JUMP_PC      = 13'h1800;  // Redirect target in bank 3
   localparam boot_pkg::adr_t PC_STEP      = boot_pkg::adr_t'(boot_pkg::WORD_BYTES);

   // Cycle budget of each test, data accesses take three cycles
   localparam int RESET_TEST_CYC = RESET_CYCLES + 4;
   localparam int FULL_TEST_CYC  = 80 * 3;
   localparam int BYTE_TEST_CYC  = 48 * 3;
   localparam int FETCH_TEST_CYC = 60;
   localparam int HELD_TEST_CYC  = 8 * 2 + 4;
   localparam int MARGIN_CYC     = 200;
   localparam int WATCHDOG_NS    = (RESET_TEST_CYC + FULL_TEST_CYC + BYTE_TEST_CYC +
                                    FETCH_TEST_CYC + HELD_TEST_CYC + MARGIN_CYC) * CLK_PERIOD;

   logic                 clk;
   logic                 reset;
   logic                 run;
   logic                 redirect;
   boot_pkg::adr_t       redirect_pc;
   boot_pkg::wb_req_t    dwb_req;
   boot_pkg::word_t      dwb_dat;
   logic                 dwb_ack;
   logic                 fetch_valid;
   boot_pkg::fetch_rsp_t fetch;

   boot_pkg::word_t model [2**(boot_pkg::ADR_W-boot_pkg::WORD_LSB)]; // Expected image
   integer          seed      = 32'hc489;
   boot_pkg::adr_t  exp_pc;                                         // Next pc to be delivered

   boot_subsys_top #(
      .RESET_PC (BOOT_PC)
   ) boot_subsys_top_inst (
      .clk           (clk),
      .reset         (reset),
      .run_i         (run),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .dwb_req_i     (dwb_req),
      .dwb_dat_o     (dwb_dat),
      .dwb_ack_o     (dwb_ack),
      .fetch_valid_o (fetch_valid),
      .fetch_o       (fetch)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_word(input string name, input boot_pkg::word_t got,
                             input boot_pkg::word_t exp);
      if (got !== exp) begin
         stop_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_fetch(input string name, input boot_pkg::fetch_rsp_t got,
                              input boot_pkg::fetch_rsp_t exp);
      if (got !== exp) begin
         stop_run($sformatf("[FAIL] t=%0t %s got pc %h instr %h expected pc %h instr %h",
                            $time, name, got.pc, got.instr, exp.pc, exp.instr));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   function automatic int word_index(input boot_pkg::adr_t adr);
      return int'(adr[boot_pkg::ADR_W-1:boot_pkg::WORD_LSB]);  // Byte offset dropped
   endfunction

   function automatic boot_pkg::fetch_rsp_t expected_fetch(input boot_pkg::adr_t pc);
      boot_pkg::fetch_rsp_t rsp;
      rsp.pc    = pc;
      rsp.instr = model[word_index(pc)];
      return rsp;
   endfunction

   // Only lanes with sel set take the new byte
   function automatic void model_write(input boot_pkg::adr_t adr,
                                       input logic [boot_pkg::SEL_W-1:0] sel,
                                       input boot_pkg::word_t dat);
      int idx;
      idx = word_index(adr);
      for (int i = 0; i < boot_pkg::SEL_W; i++) begin
         if (sel[i]) begin
            model[idx][i*boot_pkg::LANE_W +: boot_pkg::LANE_W] =
               dat[i*boot_pkg::LANE_W +: boot_pkg::LANE_W];
         end
      end
   endfunction

   // One strobe, expects ack one edge later, then drops stb
   task automatic wb_access(input boot_pkg::adr_t adr, input logic we,
                            input logic [boot_pkg::SEL_W-1:0] sel, input boot_pkg::word_t dat);
      int              edges;
      boot_pkg::word_t exp_dat;
      if (we) begin
         model_write(adr, sel, dat);
      end
      exp_dat = model[word_index(adr)];       // Write-first, a write returns the merged word
      @(posedge clk);
      dwb_req.adr <= adr;
      dwb_req.dat <= dat;
      dwb_req.we  <= we;
      dwb_req.sel <= sel;
      dwb_req.stb <= 1'b1;
      edges = 0;
      @(negedge clk);
      while (!dwb_ack) begin
         if (edges == WAIT_LIMIT) begin
            stop_run("Data port never acknowledged the strobe");
         end
         @(negedge clk);
         edges++;
      end
      if (edges != 1) begin
         stop_run($sformatf("Data port ack came %0d edges after stb, expected 1", edges));
      end
      check_word("dwb_dat_o", dwb_dat, exp_dat);
      @(posedge clk);
      dwb_req.stb <= 1'b0;                    // Seen with ack high, no second access
      dwb_req.we  <= 1'b0;
   endtask

   // First result after run_i rises, one edge after issue
   task automatic wait_fetch();
      int edges;
      edges = 0;
      @(negedge clk);
      while (!fetch_valid) begin
         if (edges == WAIT_LIMIT) begin
            stop_run("No fetch result arrived after run_i was raised");
         end
         @(negedge clk);
         edges++;
      end
      if (edges != 1) begin
         stop_run($sformatf("First fetch result came %0d edges after issue, expected 1", edges));
      end
      check_fetch("fetch_o", fetch, expected_fetch(exp_pc));
      exp_pc = exp_pc + PC_STEP;
   endtask

   task automatic next_fetch();
      @(negedge clk);
      check_bit("fetch_valid_o", fetch_valid, 1'b1);
      check_fetch("fetch_o", fetch, expected_fetch(exp_pc));
      exp_pc = exp_pc + PC_STEP;
   endtask

   task automatic reset_test();
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_bit("dwb_ack_o", dwb_ack, 1'b0);
      check_bit("fetch_valid_o", fetch_valid, 1'b0);
   endtask

   task automatic full_word_test();
      boot_pkg::adr_t bases [4];
      int             counts [4];
      boot_pkg::adr_t adr;
      bases  = '{13'h0000, 13'h07F0, 13'h1000, 13'h1800};  // One run per bank
      counts = '{4, 16, 4, 16};
      for (int b = 0; b < 4; b++) begin
         for (int i = 0; i < counts[b]; i++) begin
            adr = bases[b] + boot_pkg::adr_t'(4 * i);
            wb_access(adr, 1'b1, 4'hF, $random(seed));
         end
      end
      for (int b = 0; b < 4; b++) begin
         for (int i = 0; i < counts[b]; i++) begin
            adr = bases[b] + boot_pkg::adr_t'(4 * i);
            wb_access(adr, 1'b0, 4'h0, '0);   // Read back
         end
      end
   endtask

   task automatic byte_lane_test();
      logic [boot_pkg::SEL_W-1:0] sel;
      boot_pkg::adr_t             adr;
      for (int s = 0; s < 16; s++) begin
         sel = s[3:0];
         adr = 13'h1100 + boot_pkg::adr_t'(4 * s);
         wb_access(adr, 1'b1, 4'hF, $random(seed));  // Known base word
         wb_access(adr, 1'b1, sel, $random(seed));
         wb_access(adr, 1'b0, 4'h0, '0);
      end
   endtask

   // Boot vector first, then across the 0x7FC to 0x800 boundary
   task automatic fetch_sequence_test();
      exp_pc = BOOT_PC;                       // Held there while stopped
      @(posedge clk);
      run <= 1'b1;
      wait_fetch();
      repeat (11) next_fetch();
   endtask

   task automatic redirect_pause_test();
      @(posedge clk);
      redirect    <= 1'b1;
      redirect_pc <= JUMP_PC;
      next_fetch();                           // Delivered before the redirect edge
      @(posedge clk);
      redirect <= 1'b0;
      next_fetch();                           // Issued in the redirect cycle
      exp_pc = JUMP_PC;
      repeat (6) next_fetch();
      @(posedge clk);
      run <= 1'b0;
      next_fetch();                           // Issued before the stop was seen
      repeat (3) begin
         @(negedge clk);
         check_bit("fetch_valid_o", fetch_valid, 1'b0);
      end
      @(posedge clk);
      run <= 1'b1;
      wait_fetch();                           // Resumes at the held pc
      repeat (3) next_fetch();
      @(posedge clk);
      run <= 1'b0;
      next_fetch();
      @(negedge clk);
      check_bit("fetch_valid_o", fetch_valid, 1'b0);
   endtask

   // Strobe never dropped, address moves on after each ack
   task automatic held_strobe_test();
      boot_pkg::adr_t adr;
      adr = 13'h07F0;
      @(posedge clk);
      dwb_req.adr <= adr;
      dwb_req.we  <= 1'b0;
      dwb_req.sel <= 4'h0;
      dwb_req.stb <= 1'b1;
      for (int k = 0; k < 8; k++) begin
         @(negedge clk);
         check_bit("dwb_ack_o", dwb_ack, 1'b0);  // Gap cycle
         @(negedge clk);
         check_bit("dwb_ack_o", dwb_ack, 1'b1);
         check_word("dwb_dat_o", dwb_dat, model[word_index(adr)]);
         @(posedge clk);
         adr = adr + PC_STEP;
         if (k == 7) begin
            dwb_req.stb <= 1'b0;
         end else begin
            dwb_req.adr <= adr;               // Taken at the next edge
         end
      end
      @(negedge clk);
      check_bit("dwb_ack_o", dwb_ack, 1'b0);
   endtask

   initial begin
      reset       = 1'b1;
      run         = 1'b0;
      redirect    = 1'b0;
      redirect_pc = '0;
      dwb_req     = '0;
      reset_test();
      full_word_test();
      byte_lane_test();
      fetch_sequence_test();
      redirect_pause_test();
      held_strobe_test();
      $display("STATUS: PASS");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      stop_run($sformatf("Watchdog expired after %0d ns, a test hung", WATCHDOG_NS));
   end

endmodule

//--- boot_subsys.f
design/boot_pkg.sv
design/fetch_pc.sv
design/ram_bank.sv
design/bootram.sv
design/fetch_align.sv
design/boot_subsys_top.sv
dv/boot_subsys_sva.sv
dv/boot_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the boot memory testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module boot_subsys_tb -f boot_subsys.f -o boot_subsys_sim > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/boot_subsys_sim > sim.log 2>&1 || echo "Simulator exited with an error"

grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "Simulation did not finish, see sim.log"; exit 1; }
echo "Simulation passed"
